// ==== Makefile ====
SIM     := verilator
TOP     := sfm_tb
FLIST   := tb.f
FLAGS   := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(shell grep -v '^+' $(FLIST)) rtl/sfm_cfg.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/sfm_cfg.svh ====
`ifndef SFM_CFG_SVH
`define SFM_CFG_SVH

// vector width in lanes
`define SFM_LANES 4

// signed log2 score width
`define SFM_SCORE_W 8

// weight fraction bits, a weight of 1.0 is 1 << SFM_FRAC_W
`define SFM_FRAC_W 8

// denominator accumulator width
`define SFM_ACC_W 20

`endif

// ==== rtl/sfm_datapath.sv ====
`default_nettype none

module sfm_datapath import sfm_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        clear_i,
    input  logic        load_max_i,
    input  score_t      max_i,
    input  logic        valid_i,
    input  strb_t       strb_i,
    input  score_vec_t  data_i,
    output logic        valid_o,
    output strb_t       strb_o,
    output weight_vec_t weights_o,
    output score_t      max_o,
    output acc_t        denom_o,
    output logic        busy_o
);

    logic       in_valid;
    logic       s1_valid;
    strb_t      s1_strb;
    score_vec_t s1_data;
    shift_t     s1_shift;
    shift_t     s2_shift;
    acc_t       vect_sum;

    assign in_valid = valid_i & ~load_max_i; // a preload cycle takes no vector

    sfm_run_max u_run_max (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .clear_i    (clear_i),
        .load_max_i (load_max_i),
        .max_i      (max_i),
        .valid_i    (in_valid),
        .strb_i     (strb_i),
        .data_i     (data_i),
        .valid_o    (s1_valid),
        .strb_o     (s1_strb),
        .data_o     (s1_data),
        .max_o      (max_o),
        .shift_o    (s1_shift)
    );

    sfm_pow2_diff u_pow2_diff (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .clear_i   (clear_i),
        .valid_i   (s1_valid),
        .strb_i    (s1_strb),
        .data_i    (s1_data),
        .max_i     (max_o),
        .shift_i   (s1_shift),
        .valid_o   (valid_o),
        .strb_o    (strb_o),
        .weights_o (weights_o),
        .shift_o   (s2_shift)
    );

    sfm_red_sum u_red_sum (
        .weights_i (weights_o),
        .strb_i    (strb_o),
        .sum_o     (vect_sum)
    );

    sfm_denom_acc u_denom_acc (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .valid_i (valid_o),
        .shift_i (s2_shift),
        .sum_i   (vect_sum),
        .denom_o (denom_o)
    );

    // accumulator update lands on the edge where stage 2 empties
    assign busy_o = s1_valid | valid_o;

endmodule

`default_nettype wire

// ==== rtl/sfm_denom_acc.sv ====
`default_nettype none

`include "sfm_cfg.svh"

module sfm_denom_acc import sfm_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   clear_i,
    input  logic   valid_i,
    input  shift_t shift_i,
    input  acc_t   sum_i,
    output acc_t   denom_o
);

    acc_t denom_q;
    acc_t scaled;

    // old sum seen relative to the new max
    always_comb begin
        if (shift_i >= `SFM_ACC_W) begin
            scaled = '0;
        end else begin
            scaled = denom_q >> shift_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            denom_q <= '0;
        end else if (clear_i) begin
            denom_q <= '0;
        end else if (valid_i) begin
            denom_q <= scaled + sum_i;
        end
    end

    assign denom_o = denom_q;

endmodule

`default_nettype wire

// ==== rtl/sfm_pkg.sv ====
`default_nettype none

`include "sfm_cfg.svh"

package sfm_pkg;

    typedef logic signed [`SFM_SCORE_W-1:0] score_t;
    typedef score_t [`SFM_LANES-1:0] score_vec_t;
    typedef logic [`SFM_LANES-1:0] strb_t;

    typedef logic [`SFM_FRAC_W:0] weight_t; // unsigned, one integer bit
    typedef weight_t [`SFM_LANES-1:0] weight_vec_t;

    // wide enough for any max minus min score
    typedef logic [`SFM_SCORE_W:0] shift_t;

    typedef logic [`SFM_ACC_W-1:0] acc_t;

    localparam score_t SCORE_MIN = {1'b1, {(`SFM_SCORE_W-1){1'b0}}};

endpackage

`default_nettype wire

// ==== rtl/sfm_pow2_diff.sv ====
`default_nettype none

`include "sfm_cfg.svh"

module sfm_pow2_diff import sfm_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        clear_i,
    input  logic        valid_i,
    input  strb_t       strb_i,
    input  score_vec_t  data_i,
    input  score_t      max_i,
    input  shift_t      shift_i,
    output logic        valid_o,
    output strb_t       strb_o,
    output weight_vec_t weights_o,
    output shift_t      shift_o
);

    localparam weight_t ONE = weight_t'(1) << `SFM_FRAC_W;

    weight_vec_t weights_d;
    logic        valid_q;
    strb_t       strb_q;
    weight_vec_t weights_q;
    shift_t      shift_q;

    always_comb begin
        score_t                     lane;
        logic signed [`SFM_SCORE_W:0] diff;
        for (int l = 0; l < `SFM_LANES; l++) begin
            lane = data_i[l];
            diff = {max_i[`SFM_SCORE_W-1], max_i} - {lane[`SFM_SCORE_W-1], lane};
            // beyond FRAC_W the one is shifted out completely
            if (!strb_i[l] || (diff < 0) || (diff > `SFM_FRAC_W)) begin
                weights_d[l] = '0;
            end else begin
                weights_d[l] = ONE >> diff;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i & ~clear_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            strb_q    <= strb_i;
            weights_q <= weights_d;
            shift_q   <= shift_i; // rescale travels with its vector
        end
    end

    assign valid_o   = valid_q;
    assign strb_o    = strb_q;
    assign weights_o = weights_q;
    assign shift_o   = shift_q;

endmodule

`default_nettype wire

// ==== rtl/sfm_red_sum.sv ====
`default_nettype none

`include "sfm_cfg.svh"

module sfm_red_sum import sfm_pkg::*; (
    input  weight_vec_t weights_i,
    input  strb_t       strb_i,
    output acc_t        sum_o
);

    localparam int unsigned LEVELS = $clog2(`SFM_LANES);
    localparam int unsigned LEAVES = 1 << LEVELS;

    // heap order, node 0 is the root, leaves start at LEAVES-1
    acc_t node [2*LEAVES-1];

    for (genvar l = 0; l < LEAVES; l++) begin : g_leaf
        if (l < `SFM_LANES) begin : g_lane
            assign node[LEAVES-1+l] = strb_i[l] ? acc_t'(weights_i[l]) : '0;
        end else begin : g_pad
            assign node[LEAVES-1+l] = '0;
        end
    end

    for (genvar n = 0; n < LEAVES - 1; n++) begin : g_node
        assign node[n] = node[2*n+1] + node[2*n+2];
    end

    assign sum_o = node[0];

endmodule

`default_nettype wire

// ==== rtl/sfm_run_max.sv ====
`default_nettype none

`include "sfm_cfg.svh"

module sfm_run_max import sfm_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       clear_i,
    input  logic       load_max_i,
    input  score_t     max_i,
    input  logic       valid_i,
    input  strb_t      strb_i,
    input  score_vec_t data_i,
    output logic       valid_o,
    output strb_t      strb_o,
    output score_vec_t data_o,
    output score_t     max_o,
    output shift_t     shift_o
);

    score_t     max_q;
    score_t     max_d;
    shift_t     shift_d;
    logic       valid_q;
    strb_t      strb_q;
    score_vec_t data_q;
    shift_t     shift_q;

    // largest of the held max and the strobed lanes
    always_comb begin
        score_t lane;
        max_d = max_q;
        for (int l = 0; l < `SFM_LANES; l++) begin
            lane = data_i[l];
            if (valid_i && strb_i[l] && (lane > max_d)) begin
                max_d = lane;
            end
        end
    end

    // never negative, max only rises on a vector
    assign shift_d = {max_d[`SFM_SCORE_W-1], max_d} - {max_q[`SFM_SCORE_W-1], max_q};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            max_q   <= SCORE_MIN;
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i & ~clear_i;
            if (clear_i) begin
                max_q <= SCORE_MIN;
            end else if (load_max_i) begin
                max_q <= max_i; // preload, the vector is gated off upstream
            end else begin
                max_q <= max_d;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            data_q  <= data_i;
            strb_q  <= strb_i;
            shift_q <= shift_d;
        end
    end

    assign valid_o = valid_q;
    assign strb_o  = strb_q;
    assign data_o  = data_q;
    assign max_o   = max_q;
    assign shift_o = shift_q;

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+rtl
rtl/sfm_pkg.sv
rtl/sfm_run_max.sv
rtl/sfm_pow2_diff.sv
rtl/sfm_red_sum.sv
rtl/sfm_denom_acc.sv
rtl/sfm_datapath.sv
tests/sfm_checker.sv
tests/sfm_tb.sv

// ==== tests/sfm_checker.sv ====
`default_nettype none

`include "sfm_cfg.svh"

module sfm_checker import sfm_pkg::*; (
    input logic        clk_i,
    input logic        rst_ni,
    input logic        clear_i,
    input logic        load_max_i,
    input logic        valid_i,
    input logic        out_valid_i,
    input strb_t       out_strb_i,
    input weight_vec_t out_weights_i,
    input logic        busy_i
);

    int   latency_fails = 0;
    int   mask_fails    = 0;
    int   busy_fails    = 0;
    logic masked_nonzero;

    always_comb begin
        masked_nonzero = 1'b0;
        for (int l = 0; l < `SFM_LANES; l++) begin
            if (!out_strb_i[l] && (out_weights_i[l] != '0)) masked_nonzero = 1'b1;
        end
    end

    // two stages, a clear at either edge kills the item
    a_valid_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_i == ($past(valid_i && !load_max_i && !clear_i, 2) && !$past(clear_i)))
    else begin
        $error("valid_o does not follow the accepted valid_i two cycles later");
        latency_fails++;
    end

    a_masked_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_i |-> !masked_nonzero)
    else begin
        $error("a lane with its strobe low has a nonzero weight");
        mask_fails++;
    end

    a_busy: assert property (@(posedge clk_i) disable iff (!rst_ni) out_valid_i |-> busy_i)
    else begin
        $error("busy_o is low while valid_o is high");
        busy_fails++;
    end

endmodule

bind sfm_datapath sfm_checker u_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .load_max_i    (load_max_i),
    .valid_i       (valid_i),
    .out_valid_i   (valid_o),
    .out_strb_i    (strb_o),
    .out_weights_i (weights_o),
    .busy_i        (busy_o)
);

`default_nettype wire

// ==== tests/sfm_tb.sv ====
`default_nettype none

`include "sfm_cfg.svh"

module sfm_tb import sfm_pkg::*; ();

    localparam int NCYC    = 512;
    localparam int TIMEOUT = 40;
    localparam int VEC     = 0;
    localparam int LOAD    = 1;
    localparam int CLEAR   = 2;
    localparam int IDLE    = 3;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        clear_i;
    logic        load_max_i;
    score_t      max_i;
    logic        valid_i;
    strb_t       strb_i;
    score_vec_t  data_i;
    logic        valid_o;
    strb_t       strb_o;
    weight_vec_t weights_o;
    score_t      max_o;
    acc_t        denom_o;
    logic        busy_o;

    // stimulus table, one row per cycle
    string      t_name[$];
    int         t_kind[$];
    strb_t      t_strb[$];
    score_vec_t t_data[$];
    score_t     t_max[$];

    // expected events per cycle, filled by the model when a row is driven
    logic        ev_max[NCYC];
    score_t      ev_max_val[NCYC];
    logic        ev_den[NCYC];
    int          ev_den_val[NCYC];
    logic        ev_s1[NCYC];
    logic        ev_vld[NCYC];
    strb_t       ev_strb[NCYC];
    weight_vec_t ev_w[NCYC];

    int     m;   // model max
    int     den; // model denominator, relative to m
    score_t exp_max;
    int     exp_den;
    int     cyc;
    string  cur_name;
    int     errors;
    int     test_err;
    int     n_tests;
    int     n_failed;
    int     n_checks;
    int     bound_fails;
    logic   timed_out;

    sfm_datapath u_sfm_datapath (.*);

    always #2 clk_i = ~clk_i;

    function automatic score_vec_t mk_vec(input int l0, input int l1, input int l2, input int l3);
        mk_vec = {score_t'(l3), score_t'(l2), score_t'(l1), score_t'(l0)};
    endfunction

    function automatic int rand_score();
        rand_score = int'($urandom_range(40)) - 20;
    endfunction

    task automatic add_row(input string name, input int kind, input strb_t s,
                           input score_vec_t d, input score_t mv);
        t_name.push_back(name);
        t_kind.push_back(kind);
        t_strb.push_back(s);
        t_data.push_back(d);
        t_max.push_back(mv);
    endtask

    task automatic report_mismatch(input string what, input longint expv, input longint actv);
        errors++;
        test_err++;
        $display("Fail %s: %s expected %0d got %0d", cur_name, what, expv, actv);
    endtask

    // schedules what a row must produce at edges cyc+1 .. cyc+3
    task automatic model_row(input int kind, input strb_t s, input score_vec_t d, input score_t mv);
        int          nm;
        int          sh;
        int          sum;
        weight_vec_t w;
        if (kind == CLEAR) begin
            m = SCORE_MIN;
            den = 0;
            ev_max[cyc+1] = 1'b1;
            ev_max_val[cyc+1] = SCORE_MIN;
            ev_vld[cyc+1] = 1'b0;   // item in stage 1 is dropped
            ev_den[cyc+1] = 1'b1;
            ev_den_val[cyc+1] = 0;
            ev_den[cyc+2] = 1'b0;
        end else if (kind == LOAD) begin
            m = mv;
            ev_max[cyc+1] = 1'b1;
            ev_max_val[cyc+1] = mv;
        end else if (kind == VEC) begin
            nm = m;
            sum = 0;
            for (int l = 0; l < `SFM_LANES; l++) begin
                if (s[l] && (d[l] > nm)) nm = d[l];
            end
            for (int l = 0; l < `SFM_LANES; l++) begin
                w[l] = '0;
                if (s[l] && (nm - int'(d[l]) <= `SFM_FRAC_W)) begin
                    w[l] = weight_t'((1 << `SFM_FRAC_W) >> (nm - int'(d[l])));
                end
                sum += int'(w[l]);
            end
            sh = nm - m;
            den = ((sh >= `SFM_ACC_W) ? 0 : (den >> sh)) + sum;
            m = nm;
            ev_max[cyc+1] = 1'b1;
            ev_max_val[cyc+1] = score_t'(nm);
            ev_s1[cyc+1] = 1'b1;
            ev_vld[cyc+2] = 1'b1;
            ev_strb[cyc+2] = s;
            ev_w[cyc+2] = w;
            ev_den[cyc+3] = 1'b1;
            ev_den_val[cyc+3] = den;
        end
    endtask

    task automatic check_cycle();
        if (ev_max[cyc]) exp_max = ev_max_val[cyc];
        if (ev_den[cyc]) exp_den = ev_den_val[cyc];
        n_checks++;
        assert (max_o == exp_max) else report_mismatch("max_o", exp_max, max_o);
        assert (denom_o == acc_t'(exp_den)) else report_mismatch("denom_o", exp_den, denom_o);
        assert (valid_o == ev_vld[cyc]) else report_mismatch("valid_o", ev_vld[cyc], valid_o);
        assert (busy_o == (ev_vld[cyc] | ev_s1[cyc]))
            else report_mismatch("busy_o", ev_vld[cyc] | ev_s1[cyc], busy_o);
        if (ev_vld[cyc]) begin
            assert (weights_o == ev_w[cyc]) else report_mismatch("weights_o", ev_w[cyc], weights_o);
            assert (strb_o == ev_strb[cyc]) else report_mismatch("strb_o", ev_strb[cyc], strb_o);
        end
    endtask

    // check the current cycle, then drive row r, or idle when r < 0
    task automatic step(input int r);
        check_cycle();
        clear_i    = 1'b0;
        load_max_i = 1'b0;
        valid_i    = 1'b0;
        if (r >= 0) begin
            clear_i    = (t_kind[r] == CLEAR);
            load_max_i = (t_kind[r] == LOAD);
            valid_i    = (t_kind[r] == VEC) || (t_kind[r] == LOAD); // load cycle carries a vector
            strb_i     = t_strb[r];
            data_i     = t_data[r];
            max_i      = t_max[r];
            model_row(t_kind[r], t_strb[r], t_data[r], t_max[r]);
        end
        @(posedge clk_i);
        #1;
        cyc++;
    endtask

    task automatic finish_test();
        int n;
        n = 0;
        while (busy_o && (n < TIMEOUT)) begin
            step(-1);
            n++;
        end
        if (busy_o) begin
            timed_out = 1'b1;
            $display("busy_o stayed high for %0d cycles in test %s", TIMEOUT, cur_name);
        end
        assert (max_o == score_t'(m)) else report_mismatch("final max_o", m, max_o);
        assert (denom_o == acc_t'(den)) else report_mismatch("final denom_o", den, denom_o);
        $display("test %s: %s, %0d errors", cur_name, (test_err == 0) ? "ok" : "wrong", test_err);
        n_tests++;
        if (test_err != 0) n_failed++;
        test_err = 0;
    endtask

    task automatic build_table();
        for (int i = 0; i < 3; i++) add_row("reset", IDLE, '0, '0, '0);
        add_row("single", VEC, 4'b0111, mk_vec(5, 2, -3, 90), '0); // lane 3 masked
        add_row("stream", VEC, 4'b1111, mk_vec(1, 0, -2, 3), '0);
        add_row("stream", VEC, 4'b1111, mk_vec(4, 6, 2, 0), '0);
        add_row("stream", VEC, 4'b1011, mk_vec(10, 7, 9, 8), '0);
        add_row("stream", VEC, 4'b1111, mk_vec(-1, 2, 10, 20), '0);
        add_row("load", LOAD, 4'b1111, mk_vec(90, 90, 90, 90), score_t'(40));
        add_row("load", VEC, 4'b1111, mk_vec(38, 40, 33, 30), '0);
        add_row("load", VEC, 4'b0011, mk_vec(41, 36, 0, 0), '0);
        add_row("clear", VEC, 4'b1111, mk_vec(50, 45, 48, 44), '0);
        add_row("clear", VEC, 4'b1111, mk_vec(52, 51, 47, 49), '0);
        add_row("clear", VEC, 4'b1111, mk_vec(55, 50, 53, 54), '0);
        add_row("clear", CLEAR, '0, '0, '0);
        add_row("clear", VEC, 4'b1111, mk_vec(-5, -7, -9, -20), '0);
        add_row("clear", VEC, 4'b1101, mk_vec(-3, -4, 0, -6), '0);
        for (int i = 0; i < 40; i++) begin
            add_row("random", VEC, strb_t'($urandom_range(15)),
                    mk_vec(rand_score(), rand_score(), rand_score(), rand_score()), '0);
        end
    endtask

    initial begin
        void'($urandom(32'h24ba));
        for (int i = 0; i < NCYC; i++) begin
            ev_max[i] = 1'b0;
            ev_den[i] = 1'b0;
            ev_s1[i]  = 1'b0;
            ev_vld[i] = 1'b0;
        end
        rst_ni     = 1'b0;
        clear_i    = 1'b0;
        load_max_i = 1'b0;
        max_i      = '0;
        valid_i    = 1'b0;
        strb_i     = '0;
        data_i     = '0;
        m          = SCORE_MIN;
        den        = 0;
        exp_max    = SCORE_MIN;
        exp_den    = 0;
        cyc        = 0;
        errors     = 0;
        test_err   = 0;
        n_tests    = 0;
        n_failed   = 0;
        n_checks   = 0;
        timed_out  = 1'b0;
        build_table();
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        cur_name = t_name[0];
        for (int r = 0; (r < t_name.size()) && !timed_out; r++) begin
            if (t_name[r] != cur_name) begin
                finish_test();
                cur_name = t_name[r];
            end
            step(r);
        end
        if (!timed_out) finish_test();
        bound_fails = u_sfm_datapath.u_checker.latency_fails
                    + u_sfm_datapath.u_checker.mask_fails
                    + u_sfm_datapath.u_checker.busy_fails;
        assert (bound_fails == 0) else begin
            errors++;
            $display("bound checker assertions failed %0d times", bound_fails);
        end
        $display("%0d tests, %0d failed, %0d cycles checked, %0d errors",
                 n_tests, n_failed, n_checks, errors);
        if ((errors == 0) && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
